/* Makefile */
SRCS = banked_mem_pkg.sv bank_ram.sv write_steer.sv read_gather.sv banked_mem.sv \
       banked_mem_tb.sv

.PHONY: all run clean

all: obj_dir/Vbanked_mem_tb

# rebuilt only when a source or the file list changes
obj_dir/Vbanked_mem_tb: $(SRCS) banked_mem.f
	verilator --binary --timing --assert --top-module banked_mem_tb -f banked_mem.f

# exit status of the simulator is the test result
run: obj_dir/Vbanked_mem_tb
	./obj_dir/Vbanked_mem_tb

clean:
	rm -rf obj_dir

/* bank_ram.sv */
`timescale 1ns/1ps

module bank_ram #(
    parameter int DW = 32,                      // word width
    parameter int AW = 6                        // row address width
) (
    input  logic          rd_clk,               // single clock for both ports
    // write port
    input  logic          wr_ce,                // write chip enable
    input  logic [DW-1:0] wr_mask,              // per bit write mask
    input  logic [AW-1:0] wr_row,               // write row
    input  logic [DW-1:0] wr_din,               // write data
    // read port
    input  logic          rd_ce,                // read chip enable
    input  logic [AW-1:0] rd_row,               // read row
    output logic [DW-1:0] rd_dout               // registered read data
);

    logic [DW-1:0] mem [2**AW];                 // storage array, no reset

    // masked write, only the selected bits of the row change
    always_ff @(posedge rd_clk) begin
        if (wr_ce) begin
            for (int i = 0; i < DW; i++) begin
                if (wr_mask[i]) begin
                    mem[wr_row][i] <= wr_din[i];   // bit lane enabled
                end
            end
        end
    end

    // registered read, old word on a same edge write to the same row
    always_ff @(posedge rd_clk) begin
        if (rd_ce) begin
            rd_dout <= mem[rd_row];             // load on enable
        end                                     // else hold last word
    end

endmodule

/* banked_mem.f */
banked_mem_pkg.sv
bank_ram.sv
write_steer.sv
read_gather.sv
banked_mem.sv
banked_mem_tb.sv

/* banked_mem.sv */
`timescale 1ns/1ps

module banked_mem (
    input  logic                                 rd_clk,      // buffer clock
    input  logic                                 rst_n,       // sync, active low
    // write port
    input  logic                                 wr_en,       // write strobe
    input  logic [banked_mem_pkg::ADDR_BITS-1:0] wr_addr,     // flat word address
    input  logic [banked_mem_pkg::NUM_BYTES-1:0] wr_byte_en,  // byte lane enables
    input  logic [banked_mem_pkg::DATA_BITS-1:0] wr_data,     // write word
    // read port
    input  logic                                 rd_en,       // read strobe
    input  logic [banked_mem_pkg::ADDR_BITS-1:0] rd_addr,     // flat word address
    output logic [banked_mem_pkg::DATA_BITS-1:0] rd_data,     // read word, one cycle later
    output logic                                 rd_valid     // marks rd_data for one cycle
);

    // steer to banks
    logic [banked_mem_pkg::NUM_BANKS-1:0] bank_wr_ce;         // one hot write enables
    logic [banked_mem_pkg::ROW_BITS-1:0]  bank_wr_row;        // shared write row
    logic [banked_mem_pkg::DATA_BITS-1:0] bank_wr_mask;       // shared bit mask
    logic [banked_mem_pkg::DATA_BITS-1:0] bank_wr_data;       // shared write data

    // gather to and from banks
    logic [banked_mem_pkg::NUM_BANKS-1:0] bank_rd_ce;         // one hot read enables
    logic [banked_mem_pkg::ROW_BITS-1:0]  bank_rd_row;        // shared read row
    logic [banked_mem_pkg::NUM_BANKS*banked_mem_pkg::DATA_BITS-1:0] bank_rd_dout; // all outputs

    write_steer write_steer_i (
        .rd_clk       (rd_clk),
        .rst_n        (rst_n),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_byte_en   (wr_byte_en),
        .wr_data      (wr_data),
        .bank_wr_ce   (bank_wr_ce),
        .bank_wr_row  (bank_wr_row),
        .bank_wr_mask (bank_wr_mask),
        .bank_wr_data (bank_wr_data)
    );

    // interleaved banks, bank b holds every word with addr[1:0] == b
    for (genvar b = 0; b < banked_mem_pkg::NUM_BANKS; b++) begin : g_bank
        bank_ram #(
            .DW (banked_mem_pkg::DATA_BITS),
            .AW (banked_mem_pkg::ROW_BITS)
        ) bank_ram_i (
            .rd_clk  (rd_clk),
            .wr_ce   (bank_wr_ce[b]),                         // own enable bit
            .wr_mask (bank_wr_mask),
            .wr_row  (bank_wr_row),
            .wr_din  (bank_wr_data),
            .rd_ce   (bank_rd_ce[b]),                         // own enable bit
            .rd_row  (bank_rd_row),
            .rd_dout (bank_rd_dout[b*banked_mem_pkg::DATA_BITS +: banked_mem_pkg::DATA_BITS])
        );
    end

    read_gather read_gather_i (
        .rd_clk       (rd_clk),
        .rst_n        (rst_n),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .bank_rd_ce   (bank_rd_ce),
        .bank_rd_row  (bank_rd_row),
        .bank_rd_dout (bank_rd_dout),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid)
    );

endmodule

/* banked_mem_pkg.sv */
package banked_mem_pkg;

    // buffer geometry
    localparam int NUM_BANKS = 4;                      // bank rams behind the steer block
    localparam int BANK_BITS = 2;                      // bank index width
    localparam int ROW_BITS  = 6;                      // 64 rows in each bank
    localparam int ADDR_BITS = ROW_BITS + BANK_BITS;   // flat word address, 256 words
    localparam int DATA_BITS = 32;                     // word width
    localparam int NUM_BYTES = DATA_BITS / 8;          // byte lanes per word

    // One address word with two readings. Banks interleave on the low bits,
    // so consecutive flat indices land in consecutive banks.
    typedef union packed {
        logic [ADDR_BITS-1:0] flat;                    // linear word index
        struct packed {
            logic [ROW_BITS-1:0]  row;                 // row inside the bank
            logic [BANK_BITS-1:0] bank;                // low bits pick the bank
        } split;
    } mem_addr_u;

endpackage

/* banked_mem_tb.sv */
`timescale 1ns/1ps

module banked_mem_tb;

    localparam int TIMEOUT_CYCLES = 4000;                      // ~1.5x the full run
    localparam int MIXED_CYCLES   = 2000;                      // random traffic length

    logic                                 rd_clk     = 1'b0;
    logic                                 rst_n      = 1'b0;   // held low at start
    logic                                 wr_en      = 1'b0;
    logic [banked_mem_pkg::ADDR_BITS-1:0] wr_addr    = '0;
    logic [banked_mem_pkg::NUM_BYTES-1:0] wr_byte_en = '0;
    logic [banked_mem_pkg::DATA_BITS-1:0] wr_data    = '0;
    logic                                 rd_en      = 1'b0;
    logic [banked_mem_pkg::ADDR_BITS-1:0] rd_addr    = '0;
    logic [banked_mem_pkg::DATA_BITS-1:0] rd_data;
    logic                                 rd_valid;

    logic [31:0] seed = 32'h7d86;                              // lcg state
    logic [banked_mem_pkg::DATA_BITS-1:0] model [2**banked_mem_pkg::ADDR_BITS]; // reference
    logic                                 exp_valid = 1'b0;    // read pending this cycle
    logic [banked_mem_pkg::DATA_BITS-1:0] exp_data  = '0;      // word it should return
    logic [banked_mem_pkg::DATA_BITS-1:0] last_data = '0;      // for the hold check
    logic                                 have_last = 1'b0;
    logic                                 armed     = 1'b0;    // set once reset is seen
    int                                   reads_issued  = 0;
    int                                   reads_checked = 0;
    int                                   cycles        = 0;

    banked_mem banked_mem_i (
        .rd_clk     (rd_clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_byte_en (wr_byte_en),
        .wr_data    (wr_data),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid)
    );

    always #2 rd_clk = ~rd_clk;                                // 4 ns period

    // plain lcg, halves swapped so bit 0 is not the weak one
    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return {seed[15:0], seed[31:16]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] got);
        if (got !== expected) begin
            $display("Fail at %0t ns: %s expected %h got %h", $time, name, expected, got);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // one cycle of stimulus, applied on the rising edge
    task automatic drive(input logic we, input logic [banked_mem_pkg::ADDR_BITS-1:0] wa,
                         input logic [banked_mem_pkg::NUM_BYTES-1:0] be,
                         input logic [banked_mem_pkg::DATA_BITS-1:0] wd,
                         input logic re, input logic [banked_mem_pkg::ADDR_BITS-1:0] ra);
        @(posedge rd_clk);
        wr_en      <= we;
        wr_addr    <= wa;
        wr_byte_en <= be;
        wr_data    <= wd;
        rd_en      <= re;
        rd_addr    <= ra;
        if (re) begin
            reads_issued++;                                    // checker must see each one
        end
    endtask

    // sampled mid cycle, inputs and outputs both settled here
    always @(negedge rd_clk) begin
        if (armed) begin
            check_value("rd_valid", {31'b0, exp_valid}, {31'b0, rd_valid});
            if (exp_valid) begin
                check_value("rd_data", exp_data, rd_data);
                last_data = exp_data;
                have_last = 1'b1;
                reads_checked++;
            end else if (have_last) begin
                check_value("rd_data (hold)", last_data, rd_data);   // no read, no change
            end
        end
        if (!rst_n) begin
            armed = 1'b1;
        end
        exp_valid = rst_n && rd_en;                            // what the next edge brings
        if (rst_n && rd_en) begin
            exp_data = model[rd_addr];                         // before this edge's write
        end
        if (wr_en) begin
            for (int b = 0; b < banked_mem_pkg::NUM_BYTES; b++) begin
                if (wr_byte_en[b]) begin
                    model[wr_addr][b*8 +: 8] = wr_data[b*8 +: 8];
                end
            end
        end
    end

    // hang guard
    always @(posedge rd_clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish");
            $display("SOME TESTS FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    initial begin
        logic [31:0]                          r;
        logic [banked_mem_pkg::ADDR_BITS-1:0] wa;
        logic [banked_mem_pkg::ADDR_BITS-1:0] ra;
        logic [banked_mem_pkg::ADDR_BITS-1:0] prev_wa;
        logic [banked_mem_pkg::NUM_BYTES-1:0] be;
        banked_mem_pkg::mem_addr_u            a;

        repeat (2) @(posedge rd_clk);
        rst_n <= 1'b1;

        // fill every word, all lanes on
        for (int i = 0; i < 2**banked_mem_pkg::ADDR_BITS; i++) begin
            drive(1'b1, banked_mem_pkg::ADDR_BITS'(i), '1, next_rand(), 1'b0, '0);
        end
        // back to back readback, banks rotate each cycle
        for (int i = 0; i < 2**banked_mem_pkg::ADDR_BITS; i++) begin
            drive(1'b0, '0, '0, '0, 1'b1, banked_mem_pkg::ADDR_BITS'(i));
        end
        drive(1'b0, '0, '0, '0, 1'b0, '0);

        // partial writes, then read the merged word
        for (int i = 0; i < 64; i++) begin
            r            = next_rand();
            a.split.row  = r[13:8];                            // built from row and bank
            a.split.bank = r[1:0];
            be           = (i % 8 == 0) ? '0 : r[7:4];         // some all-zero patterns
            drive(1'b1, a.flat, be, next_rand(), 1'b0, '0);
            drive(1'b0, '0, '0, '0, 1'b1, a.flat);
        end

        // mixed traffic, every address already holds a known word
        prev_wa = '0;
        for (int i = 0; i < MIXED_CYCLES; i++) begin
            r  = next_rand();
            wa = r[15:8];
            case (r[3:2])
                2'd0:    ra = wa;                              // same edge, old word
                2'd1:    ra = prev_wa;                         // one after, new word
                default: ra = r[27:20];
            endcase
            drive(r[0], wa, r[7:4], next_rand(), r[1], ra);
            prev_wa = wa;
        end
        repeat (3) drive(1'b0, '0, '0, '0, 1'b0, '0);         // drain last read

        if (reads_issued > 0 && reads_checked == reads_issued) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("read count wrong: %0d issued, %0d checked", reads_issued, reads_checked);
            $display("SOME TESTS FAILED");
            $fatal(1, "missing read results");
        end
    end

endmodule

/* read_gather.sv */
`timescale 1ns/1ps

module read_gather (
    input  logic                                              rd_clk,       // buffer clock
    input  logic                                              rst_n,        // sync, active low
    input  logic                                              rd_en,        // read strobe
    input  logic [banked_mem_pkg::ADDR_BITS-1:0]              rd_addr,      // flat word address
    output logic [banked_mem_pkg::NUM_BANKS-1:0]              bank_rd_ce,   // one enable per bank
    output logic [banked_mem_pkg::ROW_BITS-1:0]               bank_rd_row,  // shared row bus
    input  logic [banked_mem_pkg::NUM_BANKS*banked_mem_pkg::DATA_BITS-1:0] bank_rd_dout,
    output logic [banked_mem_pkg::DATA_BITS-1:0]              rd_data,      // selected bank word
    output logic                                              rd_valid      // one cycle pulse
);

    banked_mem_pkg::mem_addr_u            addr;                 // decoded read address
    logic [banked_mem_pkg::BANK_BITS-1:0] sel_q;                // bank read last cycle

    assign addr.flat = rd_addr;                                 // load as flat index

    // enable only the addressed bank
    always_comb begin
        bank_rd_ce = '0;
        if (rd_en) begin
            bank_rd_ce[addr.split.bank] = 1'b1;
        end
    end

    assign bank_rd_row = addr.split.row;                        // row shared by all banks

    // remember the bank for the cycle its data appears
    always_ff @(posedge rd_clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
            sel_q    <= '0;
        end else begin
            rd_valid <= rd_en;                                  // data lands one edge later
            if (rd_en) begin
                sel_q <= addr.split.bank;
            end                                                 // hold keeps rd_data stable
        end
    end

    // output mux after the select register
    assign rd_data = bank_rd_dout[sel_q*banked_mem_pkg::DATA_BITS +: banked_mem_pkg::DATA_BITS];

    // valid only ever follows a read strobe
    a_valid_after_en : assert property (
        @(posedge rd_clk) disable iff (!rst_n)
        rd_valid |-> $past(rd_en)
    ) else $error("read_gather: rd_valid without rd_en one cycle earlier");

    // a read strobe wakes exactly one bank
    a_rd_ce_onehot : assert property (
        @(posedge rd_clk) disable iff (!rst_n)
        rd_en |-> $onehot(bank_rd_ce)
    ) else $error("read_gather: bank_rd_ce not one-hot on rd_en");

endmodule

/* write_steer.sv */
`timescale 1ns/1ps

module write_steer (
    input  logic                                rd_clk,        // assertion clock only
    input  logic                                rst_n,         // assertion disable only
    input  logic                                wr_en,         // write strobe
    input  logic [banked_mem_pkg::ADDR_BITS-1:0] wr_addr,      // flat word address
    input  logic [banked_mem_pkg::NUM_BYTES-1:0] wr_byte_en,   // byte lane enables
    input  logic [banked_mem_pkg::DATA_BITS-1:0] wr_data,      // write word
    output logic [banked_mem_pkg::NUM_BANKS-1:0] bank_wr_ce,   // one enable per bank
    output logic [banked_mem_pkg::ROW_BITS-1:0]  bank_wr_row,  // shared row bus
    output logic [banked_mem_pkg::DATA_BITS-1:0] bank_wr_mask, // shared bit mask
    output logic [banked_mem_pkg::DATA_BITS-1:0] bank_wr_data  // shared data bus
);

    banked_mem_pkg::mem_addr_u addr;                           // decoded write address

    assign addr.flat = wr_addr;                                // load as flat index

    // one hot bank select from the low address bits
    always_comb begin
        bank_wr_ce = '0;
        if (wr_en) begin
            bank_wr_ce[addr.split.bank] = 1'b1;                // only the addressed bank
        end
    end

    assign bank_wr_row  = addr.split.row;                      // row is the same for all banks
    assign bank_wr_data = wr_data;                             // data fans out unchanged

    // each byte enable covers eight mask bits
    always_comb begin
        for (int b = 0; b < banked_mem_pkg::NUM_BYTES; b++) begin
            bank_wr_mask[b*8 +: 8] = {8{wr_byte_en[b]}};
        end
    end

    // exactly one bank sees a write strobe, and none without one
    a_wr_ce_onehot : assert property (
        @(posedge rd_clk) disable iff (!rst_n)
        $onehot0(bank_wr_ce) && ((|bank_wr_ce) == wr_en)
    ) else $error("write_steer: bank_wr_ce not one-hot with wr_en");

endmodule
